//--- rtl/pool_consts.svh
`ifndef POOL_CONSTS_SVH
`define POOL_CONSTS_SVH

// datapath widths
`define POOL_DATA_W     16  // one fp16 word
`define POOL_SIZE_W     8   // window size, 1 to 255

// fp16 fields
`define FP16_EXP_W      5
`define FP16_MAN_W      10
`define FP16_BIAS       15

// 11 mantissa bits, guard, round and one normalization bit
`define FP16_DIV_ITERS  14

`endif

//--- rtl/pool_pkg.sv
`include "pool_consts.svh"

package pool_pkg;

    typedef struct packed {
        logic                   sign;
        logic [`FP16_EXP_W-1:0] exp;
        logic [`FP16_MAN_W-1:0] man;
    } fp16_t;

    typedef enum logic {
        POOL_AVG = 1'b0,
        POOL_MAX = 1'b1
    } pool_op_t;

    typedef struct packed {
        pool_op_t                op;
        logic [`POOL_SIZE_W-1:0] size;
    } pool_cmd_t;

    // op tells the host which unit answered
    typedef struct packed {
        pool_op_t op;
        fp16_t    value;
    } pool_result_t;

    typedef enum logic [1:0] {
        AVG_IDLE,
        AVG_ACCUM,
        AVG_DIVIDE,
        AVG_DONE
    } avg_state_t;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_ROUND} div_state_t;

endpackage

//--- rtl/fp16_add.sv
`timescale 1ns/1ps

module fp16_add (
    input  pool_pkg::fp16_t a,
    input  pool_pkg::fp16_t b,
    output pool_pkg::fp16_t sum
);
    import pool_pkg::*;

    fp16_t             fa;
    fp16_t             fb;
    fp16_t             hi;          // larger magnitude
    fp16_t             lo;
    logic [4:0]        shift;
    logic [13:0]       hi_m;
    logic [13:0]       lo_m;
    logic [27:0]       lo_ext;
    logic [13:0]       lo_al;
    logic              sub;
    logic [14:0]       raw;
    logic [3:0]        lz;
    logic [13:0]       norm;
    logic signed [6:0] exp_n;
    logic              round_up;
    logic [11:0]       rounded;
    logic signed [6:0] exp_r;

    // subnormals flush to zero
    assign fa = (a.exp == '0) ? '0 : a;
    assign fb = (b.exp == '0) ? '0 : b;

    always_comb begin
        if ({fa.exp, fa.man} >= {fb.exp, fb.man}) begin
            hi = fa;
            lo = fb;
        end else begin
            hi = fb;
            lo = fa;
        end
    end

    // hidden bit, mantissa, then guard/round/sticky
    assign hi_m   = {hi.exp != '0, hi.man, 3'b000};
    assign lo_m   = {lo.exp != '0, lo.man, 3'b000};
    assign shift  = hi.exp - lo.exp;
    assign lo_ext = {lo_m, 14'b0} >> shift;

    always_comb begin
        if (shift > 5'd14)
            lo_al = {13'b0, |lo_m};   // only sticky survives
        else
            lo_al = {lo_ext[27:15], lo_ext[14] | (|lo_ext[13:0])};
    end

    assign sub = hi.sign ^ lo.sign;
    assign raw = sub ? {1'b0, hi_m} - {1'b0, lo_al} : {1'b0, hi_m} + {1'b0, lo_al};

    // leading zero count below the carry bit
    always_comb begin
        lz = 4'd0;
        for (int i = 0; i < 14; i++) begin
            if (raw[i])
                lz = 4'(13 - i);
        end
    end

    always_comb begin
        if (raw[14]) begin
            norm  = {raw[14:2], raw[1] | raw[0]};
            exp_n = $signed({2'b00, hi.exp}) + 7'sd1;
        end else begin
            norm  = raw[13:0] << lz;
            exp_n = $signed({2'b00, hi.exp}) - $signed({3'b000, lz});
        end
    end

    // nearest even
    assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    assign rounded  = {1'b0, norm[13:3]} + {11'b0, round_up};
    assign exp_r    = rounded[11] ? exp_n + 7'sd1 : exp_n;

    always_comb begin
        if (raw == '0)
            sum = '0;   // exact cancellation gives +0
        else if (exp_r <= 7'sd0)
            sum = '{sign: hi.sign, exp: '0, man: '0};
        else if (exp_r >= 7'sd31)
            sum = '{sign: hi.sign, exp: '1, man: '0};
        else
            sum = '{sign: hi.sign, exp: exp_r[4:0], man: rounded[11] ? 10'b0 : rounded[9:0]};
    end

endmodule

//--- rtl/fp16_div.sv
`timescale 1ns/1ps
`include "pool_consts.svh"

module fp16_div (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  pool_pkg::fp16_t num,
    input  pool_pkg::fp16_t den,
    output logic            done,
    output pool_pkg::fp16_t quot
);
    import pool_pkg::*;

    localparam int QW = `FP16_DIV_ITERS;

    div_state_t        state;
    logic [3:0]        iter;
    logic              q_sign;
    logic              q_zero;
    logic signed [7:0] q_exp;       // biased, before normalization
    logic [11:0]       rem;
    logic [10:0]       dmant;
    logic [QW-1:0]     qbits;

    logic [10:0]       mant;
    logic              guard;
    logic              sticky;
    logic              round_up;
    logic [11:0]       rounded;
    logic signed [7:0] exp_adj;
    logic signed [7:0] exp_fin;
    fp16_t             packed_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DIV_IDLE;
            iter  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        iter  <= '0;
                        state <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    iter <= iter + 4'd1;
                    if (iter == 4'(QW - 1))
                        state <= DIV_ROUND;
                end
                DIV_ROUND: begin
                    done  <= 1'b1;
                    state <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            q_sign <= num.sign ^ den.sign;
            q_zero <= (num.exp == '0);
            q_exp  <= $signed({3'b000, num.exp}) - $signed({3'b000, den.exp})
                      + $signed(8'(`FP16_BIAS));
            rem    <= {1'b0, 1'b1, num.man};
            dmant  <= {1'b1, den.man};
            qbits  <= '0;
        end else if (state == DIV_RUN) begin
            // restoring step, one quotient bit per cycle
            if (rem >= {1'b0, dmant}) begin
                rem   <= (rem - {1'b0, dmant}) << 1;
                qbits <= {qbits[QW-2:0], 1'b1};
            end else begin
                rem   <= rem << 1;
                qbits <= {qbits[QW-2:0], 1'b0};
            end
        end
        if (state == DIV_ROUND)
            quot <= packed_q;
    end

    always_comb begin
        if (qbits[QW-1]) begin
            mant    = qbits[QW-1 -: 11];
            guard   = qbits[QW-12];
            sticky  = (|qbits[QW-13:0]) | (rem != '0);
            exp_adj = q_exp;
        end else begin
            mant    = qbits[QW-2 -: 11];   // quotient below 1
            guard   = qbits[QW-13];
            sticky  = qbits[QW-14] | (rem != '0);
            exp_adj = q_exp - 8'sd1;
        end
        round_up = guard & (sticky | mant[0]);
        rounded  = {1'b0, mant} + {11'b0, round_up};
        exp_fin  = rounded[11] ? exp_adj + 8'sd1 : exp_adj;

        if (q_zero || exp_fin <= 8'sd0)
            packed_q = '{sign: q_sign, exp: '0, man: '0};
        else if (exp_fin >= 8'sd31)
            packed_q = '{sign: q_sign, exp: '1, man: '0};
        else
            packed_q = '{sign: q_sign, exp: exp_fin[4:0], man: rounded[9:0]};
    end

    assert property (@(posedge clk) disable iff (!rst) start |-> den.exp != '0)
        else $error("fp16_div started with zero divisor");

    assert property (@(posedge clk) disable iff (!rst) start |-> state == DIV_IDLE)
        else $error("fp16_div restarted while running");

endmodule

//--- rtl/avg_pool_unit.sv
`timescale 1ns/1ps
`include "pool_consts.svh"

module avg_pool_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`POOL_SIZE_W-1:0] size,
    input  logic                    in_valid,
    input  pool_pkg::fp16_t         in_data,
    output logic                    busy,
    output logic                    result_valid,
    output pool_pkg::fp16_t         result
);
    import pool_pkg::*;

    avg_state_t              state;
    logic [`POOL_SIZE_W-1:0] remaining;
    fp16_t                   acc;
    fp16_t                   acc_next;
    fp16_t                   divisor;
    fp16_t                   size_fp;
    fp16_t                   quot;
    logic                    div_start;
    logic                    div_done;
    logic [2:0]              msb;
    logic [10:0]             size_norm;

    // window size as fp16, exact since it fits the mantissa
    always_comb begin
        msb = 3'd0;
        for (int i = 0; i < `POOL_SIZE_W; i++) begin
            if (size[i])
                msb = 3'(i);
        end
        size_norm = 11'(size) << (4'd10 - {1'b0, msb});
        size_fp   = '{sign: 1'b0, exp: 5'(`FP16_BIAS) + 5'(msb), man: size_norm[9:0]};
    end

    fp16_add add_i (
        .a   (acc),
        .b   (in_data),
        .sum (acc_next)
    );

    fp16_div div_i (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .num   (acc),
        .den   (divisor),
        .done  (div_done),
        .quot  (quot)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= AVG_IDLE;
            remaining    <= '0;
            div_start    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            div_start    <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                AVG_IDLE: begin
                    if (start) begin
                        remaining <= size;
                        state     <= AVG_ACCUM;
                    end
                end
                AVG_ACCUM: begin
                    if (in_valid) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == 1) begin   // last element
                            div_start <= 1'b1;
                            state     <= AVG_DIVIDE;
                        end
                    end
                end
                AVG_DIVIDE: begin
                    if (div_done) begin
                        result_valid <= 1'b1;
                        state        <= AVG_DONE;
                    end
                end
                AVG_DONE: state <= AVG_IDLE;
                default:  state <= AVG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == AVG_IDLE && start) begin
            acc     <= '0;
            divisor <= size_fp;
        end else if (state == AVG_ACCUM && in_valid) begin
            acc <= acc_next;
        end
        if (div_done)
            result <= quot;
    end

    assign busy = (state != AVG_IDLE);

    assert property (@(posedge clk) disable iff (!rst) in_valid |-> state == AVG_ACCUM)
        else $error("avg element outside accumulate phase");

endmodule

//--- rtl/max_pool_unit.sv
`timescale 1ns/1ps
`include "pool_consts.svh"

module max_pool_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`POOL_SIZE_W-1:0] size,
    input  logic                    in_valid,
    input  pool_pkg::fp16_t         in_data,
    output logic                    busy,
    output logic                    result_valid,
    output pool_pkg::fp16_t         result
);
    import pool_pkg::*;

    logic                    active;
    logic                    have_max;   // low until the first element
    logic [`POOL_SIZE_W-1:0] remaining;
    fp16_t                   cur_max;
    logic                    take;

    // unsigned key with the same order as the fp16 values
    function automatic logic [`POOL_DATA_W-1:0] order_key(fp16_t v);
        logic [`POOL_DATA_W-2:0] mag;
        mag = {v.exp, v.man};
        if (v.exp == '0)
            return {1'b1, {(`POOL_DATA_W-1){1'b0}}};   // both zeros rank as +0
        else if (v.sign)
            return {1'b0, ~mag};
        else
            return {1'b1, mag};
    endfunction

    assign take = !have_max || (order_key(in_data) > order_key(cur_max));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            active       <= 1'b0;
            have_max     <= 1'b0;
            remaining    <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (start) begin
                active    <= 1'b1;
                have_max  <= 1'b0;
                remaining <= size;
            end else if (active && in_valid) begin
                have_max  <= 1'b1;
                remaining <= remaining - 1'b1;
                if (remaining == 1) begin
                    active       <= 1'b0;
                    result_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && in_valid && take)
            cur_max <= in_data;
        if (active && in_valid && remaining == 1)
            result <= take ? in_data : cur_max;
    end

    assign busy = active | result_valid;

    assert property (@(posedge clk) disable iff (!rst) in_valid |-> active)
        else $error("max element with no window open");

endmodule

//--- rtl/pool_engine.sv
`timescale 1ns/1ps

module pool_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  pool_pkg::pool_cmd_t    cmd,
    input  logic                   in_valid,
    input  pool_pkg::fp16_t        in_data,
    output logic                   busy,
    output logic                   result_valid,
    output pool_pkg::pool_result_t result
);
    import pool_pkg::*;

    pool_op_t op_q;
    pool_op_t sel_op;
    logic     avg_start, max_start;
    logic     avg_in_valid, max_in_valid;
    logic     avg_busy, max_busy;
    logic     avg_valid, max_valid;
    fp16_t    avg_result, max_result;

    assign sel_op       = start ? cmd.op : op_q;   // latched op once running
    assign avg_start    = start && sel_op == POOL_AVG;
    assign max_start    = start && sel_op == POOL_MAX;
    assign avg_in_valid = in_valid && sel_op == POOL_AVG;
    assign max_in_valid = in_valid && sel_op == POOL_MAX;

    avg_pool_unit avg_i (
        .clk          (clk),
        .rst          (rst),
        .start        (avg_start),
        .size         (cmd.size),
        .in_valid     (avg_in_valid),
        .in_data      (in_data),
        .busy         (avg_busy),
        .result_valid (avg_valid),
        .result       (avg_result)
    );

    max_pool_unit max_i (
        .clk          (clk),
        .rst          (rst),
        .start        (max_start),
        .size         (cmd.size),
        .in_valid     (max_in_valid),
        .in_data      (in_data),
        .busy         (max_busy),
        .result_valid (max_valid),
        .result       (max_result)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_q         <= POOL_AVG;
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            if (start)
                op_q <= cmd.op;
            result_valid <= avg_valid | max_valid;
            if (avg_valid || max_valid)
                result <= '{op: op_q, value: (op_q == POOL_MAX) ? max_result : avg_result};
        end
    end

    // held high through the registered result pulse
    assign busy = avg_busy | max_busy | result_valid;

    assert property (@(posedge clk) disable iff (!rst) start |-> !busy)
        else $error("command issued while engine busy");

endmodule

//--- bench/pool_tb.sv
`timescale 1ns/1ps
`include "pool_consts.svh"

module pool_tb;
    import pool_pkg::*;

    localparam int MAX_GAP = 3;

    logic         clk;
    logic         rst;
    logic         start;
    pool_cmd_t    cmd;
    logic         in_valid;
    fp16_t        in_data;
    logic         busy;
    logic         result_valid;
    pool_result_t result;

    logic [31:0]  rng_state;
    fp16_t        win [256];     // elements of the window being sent
    fp16_t        exp_value_q[$];
    pool_op_t     exp_op_q[$];
    string        name_q[$];
    pool_op_t     cur_op;
    int           cmds_started;
    int           results_seen;
    int           cycles;
    int           deadline;
    int           size;

    pool_engine dut_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .cmd          (cmd),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int rand_below(int bound);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 32'(bound));
    endfunction

    // normal values only, exponent 10 to 20
    function automatic fp16_t random_elem();
        fp16_t v;
        v.sign = (rand_below(2) == 1);
        v.exp  = 5'(10 + rand_below(11));
        v.man  = 10'(rand_below(1024));
        return v;
    endfunction

    function automatic real fp16_to_real(fp16_t v);
        real m;
        int  e;
        if (v.exp == '0)
            return 0.0;
        m = 1.0 + $itor(v.man) / 1024.0;
        e = int'(v.exp) - `FP16_BIAS;
        while (e > 0) begin
            m = m * 2.0;
            e--;
        end
        while (e < 0) begin
            m = m / 2.0;
            e++;
        end
        return v.sign ? -m : m;
    endfunction

    // nearest even, flush below normal, saturate to infinity
    function automatic fp16_t real_to_fp16(real x);
        fp16_t r;
        logic  s;
        real   a;
        real   frac;
        int    e;
        int    m;
        r = '0;
        if (x == 0.0)
            return r;
        s = (x < 0.0);
        a = s ? -x : x;
        e = 0;
        while (a >= 2.0) begin
            a = a / 2.0;
            e++;
        end
        while (a < 1.0) begin
            a = a * 2.0;
            e--;
        end
        frac = a * 1024.0;
        m    = $rtoi(frac);
        frac = frac - $itor(m);
        if (frac > 0.5 || (frac == 0.5 && m % 2 == 1))
            m++;
        if (m == 2048) begin
            m = 1024;
            e++;
        end
        e = e + `FP16_BIAS;
        r.sign = s;
        if (e >= 31) begin
            r.exp = '1;
        end else if (e > 0) begin
            r.exp = 5'(e);
            r.man = 10'(m - 1024);
        end
        return r;
    endfunction

    function automatic fp16_t expected_result(pool_op_t op, int n);
        fp16_t acc;
        acc = win[0];
        if (op == POOL_MAX) begin
            for (int i = 1; i < n; i++) begin
                if (fp16_to_real(win[i]) > fp16_to_real(acc))   // first of equals kept
                    acc = win[i];
            end
            return acc;
        end
        acc = '0;
        for (int i = 0; i < n; i++)
            acc = real_to_fp16(fp16_to_real(acc) + fp16_to_real(win[i]));
        if (acc.exp == '0)
            return acc;   // signed zero over a positive count
        return real_to_fp16(fp16_to_real(acc) / $itor(n));
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(string name, fp16_t expected, fp16_t actual);
        logic [`POOL_DATA_W-1:0] e_bits;
        logic [`POOL_DATA_W-1:0] a_bits;
        e_bits = expected;
        a_bits = actual;
        if (a_bits !== e_bits)
            fail_now($sformatf("FAILED %s: expected %h, actual %h", name, e_bits, a_bits));
    endtask

    task automatic check_op(string name, pool_op_t expected, pool_op_t actual);
        if (actual !== expected)
            fail_now($sformatf("FAILED %s: expected op %s, actual op %s",
                               name, expected.name(), actual.name()));
    endtask

    task automatic fill_random(int n);
        for (int i = 0; i < n; i++) begin
            if (i > 0 && rand_below(4) == 0)
                win[i] = win[i-1];   // repeated value
            else
                win[i] = random_elem();
        end
    endtask

    // called at 2 ns after a rising edge, returns at the same phase
    task automatic issue_window(string name, pool_op_t op, int n, int max_gap);
        int gap;
        exp_value_q.push_back(expected_result(op, n));
        exp_op_q.push_back(op);
        name_q.push_back(name);
        while (busy) begin
            @(posedge clk);
            #2;
        end
        start    = 1'b1;
        cmd.op   = op;
        cmd.size = n[`POOL_SIZE_W-1:0];
        cur_op   = op;
        deadline = cycles + n * (max_gap + 1) + 50;
        @(posedge clk);
        #2;
        start = 1'b0;
        cmds_started++;
        for (int i = 0; i < n; i++) begin
            gap = (max_gap > 0) ? rand_below(max_gap + 1) : 0;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            in_valid = 1'b1;
            in_data  = win[i];
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    // compare process, outputs settled at the falling edge
    always @(negedge clk) begin
        if (rst && cmds_started > results_seen) begin
            if (!busy)
                fail_now("busy dropped while a window was still open");
            if (cur_op == POOL_AVG && !result_valid && dut_i.avg_i.state == AVG_IDLE)
                fail_now("average unit went idle before returning its result");
        end
        if (result_valid) begin
            if (exp_value_q.size() == 0)
                fail_now("result_valid pulsed with no command outstanding");
            check_value(name_q[0], exp_value_q.pop_front(), result.value);
            check_op(name_q.pop_front(), exp_op_q.pop_front(), result.op);
            results_seen++;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > deadline)
                fail_now("watchdog expired, the engine never returned a result");
        end
    end

    initial begin
        rng_state    = 32'h3258;
        rst          = 1'b0;
        start        = 1'b0;
        cmd          = '0;
        in_valid     = 1'b0;
        in_data      = '0;
        cur_op       = POOL_AVG;
        cmds_started = 0;
        deadline     = 200;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;

        repeat (10) begin
            @(negedge clk);
            if (busy || result_valid)
                fail_now("busy or result_valid went high before any command");
        end
        @(posedge clk);
        #2;

        for (int n = 0; n < 40; n++) begin
            size = (n == 0) ? 1 : rand_below(255) + 1;
            fill_random(size);
            issue_window($sformatf("max window %0d size %0d", n, size), POOL_MAX, size, 0);
        end

        for (int n = 0; n < 40; n++) begin
            if (n == 0)
                size = 1;
            else if (n == 1)
                size = 255;
            else
                size = rand_below(255) + 1;
            fill_random(size);
            issue_window($sformatf("avg window %0d size %0d", n, size), POOL_AVG, size, 0);
        end

        // exact cancellation, then an average under the normal range
        win[0] = 16'h4500;
        win[1] = 16'hc500;
        win[2] = 16'h3c00;
        win[3] = 16'hbc00;
        issue_window("avg cancel", POOL_AVG, 4, 0);
        win[0] = 16'h0400;
        win[1] = 16'h0400;
        win[2] = 16'h0000;
        win[3] = 16'h0000;
        win[4] = 16'h0000;
        issue_window("avg underflow", POOL_AVG, 5, 0);

        for (int n = 0; n < 8; n++) begin
            size = rand_below(64) + 1;
            fill_random(size);
            issue_window($sformatf("dense window %0d", n), pool_op_t'(n % 2), size, 0);
            issue_window($sformatf("gapped window %0d", n), pool_op_t'(n % 2), size, MAX_GAP);
        end

        for (int n = 0; n < 12; n++) begin
            size = rand_below(32) + 1;
            fill_random(size);
            issue_window($sformatf("alternating %0d", n),
                         (n % 2 == 1) ? POOL_MAX : POOL_AVG, size, 0);
        end

        while (busy) begin
            @(posedge clk);
            #2;
        end
        repeat (5) @(posedge clk);
        if (exp_value_q.size() == 0 && results_seen == cmds_started) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_now("a command finished without returning its result");
        end
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/pool_pkg.sv
rtl/fp16_add.sv
rtl/fp16_div.sv
rtl/avg_pool_unit.sv
rtl/max_pool_unit.sv
rtl/pool_engine.sv
bench/pool_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pool_tb -f sim.f -o pool_sim

out=$(./obj_dir/pool_sim 2>&1 || true)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "All tests passed"
